// File: Bender.yml
package:
  name: mmu_top

sources:
  # Packages first, then RTL leaves and the top level
  - logic/mmu_addr_pkg.sv
  - logic/mmu_cmd_pkg.sv
  - logic/mmu_cmd_decode.sv
  - logic/mmu_dtlb.sv
  - logic/mmu_ptw.sv
  - logic/mmu_data_mem.sv
  - logic/mmu_resp.sv
  - logic/mmu_top.sv
  - target: test
    files:
      - tb/mmu_top_tb.sv

// File: logic/mmu_addr_pkg.sv
// MMU address definitions
// Virtual and physical address fields, page table entry and memory word views
package mmu_addr_pkg;

  localparam int VADDR_W  = 16;
  localparam int VPN_W    = 8;
  localparam int OFFSET_W = 8;

  localparam int PPN_W    = 2;
  localparam int PADDR_W  = PPN_W + OFFSET_W;
  localparam int WORD_W   = 32;

  // One-level page table entry
  typedef struct packed {
    logic                    valid;
    logic                    writable;
    logic [WORD_W-PPN_W-3:0] rsvd;
    logic [PPN_W-1:0]        ppn;
  } pte_s;

  // One memory word, read as raw data or as a PTE
  typedef union packed {
    logic [WORD_W-1:0] data;
    pte_s              pte;
  } mem_word_u;

endpackage

// File: logic/mmu_cmd_decode.sv
`timescale 1ns/1ps
// MMU command decode and issue stage
// Holds translation control, stalls on TLB misses and decides page faults
module mmu_cmd_decode (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             cmd_v_i,
  input  mmu_cmd_pkg::mmu_op_e             cmd_op_i,
  input  logic [mmu_addr_pkg::VADDR_W-1:0] cmd_vaddr_i,
  input  logic [mmu_addr_pkg::WORD_W-1:0]  cmd_data_i,
  input  logic                             tlb_hit_i,
  input  logic [mmu_addr_pkg::PPN_W-1:0]   tlb_ppn_i,
  input  logic                             tlb_writable_i,
  input  logic                             ptw_done_i,
  input  logic                             ptw_fault_i,
  output logic                             cmd_ready_o,
  output logic [mmu_addr_pkg::VPN_W-1:0]   tlb_vpn_o,
  output logic                             tlb_flush_o,
  output logic                             miss_v_o,
  output logic [mmu_addr_pkg::VPN_W-1:0]   miss_vpn_o,
  output logic [mmu_addr_pkg::PPN_W-1:0]   base_ppn_o,
  output logic                             mem_v_o,
  output logic                             mem_we_o,
  output logic [mmu_addr_pkg::PADDR_W-1:0] mem_addr_o,
  output logic [mmu_addr_pkg::WORD_W-1:0]  mem_wdata_o,
  output logic                             iss_v_o,
  output mmu_cmd_pkg::mmu_op_e             iss_op_o,
  output logic                             iss_fault_o
);
  import mmu_addr_pkg::*;
  import mmu_cmd_pkg::*;

  logic                xlate_en_q;
  logic [PPN_W-1:0]    base_ppn_q;
  logic                iss_v_q;
  mmu_op_e             iss_op_q;
  logic [OFFSET_W-1:0] iss_off_q;
  logic [VPN_W-1:0]    iss_vpn_q;
  logic [WORD_W-1:0]   iss_wdata_q;
  logic                iss_xlate_q;
  logic                iss_hit_q;
  logic [PPN_W-1:0]    iss_ppn_q;
  logic                iss_wr_q;
  logic                walk_q;
  logic                relook_q;
  logic                pf_q;
  logic                accept;
  logic                iss_mem;
  logic                stall;
  logic                store_ro;

  assign iss_mem = (iss_op_q == OP_LOAD) || (iss_op_q == OP_STORE);
  // Translated access without a TLB entry waits for the walker
  assign stall   = iss_v_q && iss_xlate_q && iss_mem && !iss_hit_q && !pf_q;

  assign cmd_ready_o = !stall;
  assign accept      = cmd_v_i && cmd_ready_o;
  assign tlb_vpn_o   = stall ? iss_vpn_q : cmd_vaddr_i[VADDR_W-1:OFFSET_W];
  assign tlb_flush_o = accept && (cmd_op_i == OP_FENCE);
  assign miss_v_o    = stall && !walk_q;
  assign miss_vpn_o  = iss_vpn_q;
  assign base_ppn_o  = base_ppn_q;

  assign store_ro    = (iss_op_q == OP_STORE) && iss_hit_q && !iss_wr_q;
  assign iss_fault_o = iss_xlate_q && iss_mem && (pf_q || store_ro);
  assign iss_v_o     = iss_v_q && !stall;
  assign iss_op_o    = iss_op_q;

  assign mem_v_o     = iss_v_o && iss_mem && !iss_fault_o;
  assign mem_we_o    = (iss_op_q == OP_STORE);
  assign mem_addr_o  = {(iss_xlate_q ? iss_ppn_q : iss_vpn_q[PPN_W-1:0]), iss_off_q};
  assign mem_wdata_o = iss_wdata_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      xlate_en_q <= 1'b0;
      base_ppn_q <= '0;
      iss_v_q    <= 1'b0;
      walk_q     <= 1'b0;
      relook_q   <= 1'b0;
      pf_q       <= 1'b0;
    end else begin
      if (accept && (cmd_op_i == OP_SATP)) begin
        xlate_en_q <= cmd_data_i[SATP_EN_BIT];
        base_ppn_q <= cmd_data_i[PPN_W-1:0];
      end
      if (!stall) begin
        iss_v_q <= accept;
      end
      relook_q <= ptw_done_i;
      if (miss_v_o) begin
        walk_q <= 1'b1;
      end else if (relook_q || ptw_fault_i) begin
        walk_q <= 1'b0;
      end
      if (ptw_fault_i) begin
        pf_q <= 1'b1;
      end else if (!stall) begin
        pf_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      iss_op_q    <= cmd_op_i;
      iss_off_q   <= cmd_vaddr_i[OFFSET_W-1:0];
      iss_vpn_q   <= cmd_vaddr_i[VADDR_W-1:OFFSET_W];
      iss_wdata_q <= cmd_data_i;
      iss_xlate_q <= xlate_en_q;
      iss_hit_q   <= tlb_hit_i;
      iss_ppn_q   <= tlb_ppn_i;
      iss_wr_q    <= tlb_writable_i;
    end else if (relook_q) begin
      // Second lookup after refill
      iss_hit_q <= tlb_hit_i;
      iss_ppn_q <= tlb_ppn_i;
      iss_wr_q  <= tlb_writable_i;
    end
  end

  // Walker only answers while a miss is held
  assert property (@(posedge clk_i) disable iff (reset_i)
    (ptw_done_i || ptw_fault_i) |-> (walk_q && stall));

endmodule

// File: logic/mmu_cmd_pkg.sv
// MMU command and response encodings
package mmu_cmd_pkg;

  typedef enum logic [1:0] {
    OP_LOAD  = 2'd0,
    OP_STORE = 2'd1,
    OP_SATP  = 2'd2,
    OP_FENCE = 2'd3
  } mmu_op_e;

  // Translation enable in the OP_SATP write data
  localparam int SATP_EN_BIT = 31;

  typedef enum logic [1:0] {
    CAUSE_NONE     = 2'd0,
    CAUSE_LOAD_PF  = 2'd1,
    CAUSE_STORE_PF = 2'd2
  } mmu_cause_e;

endpackage

// File: logic/mmu_data_mem.sv
`timescale 1ns/1ps
// Single-port word memory shared by the access stage and the walker
module mmu_data_mem (
  input  logic                             clk_i,
  input  logic                             acc_v_i,
  input  logic                             acc_we_i,
  input  logic [mmu_addr_pkg::PADDR_W-1:0] acc_addr_i,
  input  logic [mmu_addr_pkg::WORD_W-1:0]  acc_wdata_i,
  input  logic                             ptw_re_i,
  input  logic [mmu_addr_pkg::PADDR_W-1:0] ptw_addr_i,
  output logic [mmu_addr_pkg::WORD_W-1:0]  rdata_o
);
  import mmu_addr_pkg::*;

  localparam int DEPTH = 2 ** PADDR_W;

  logic [WORD_W-1:0]  mem_q [DEPTH];
  logic [PADDR_W-1:0] addr;
  logic               en;
  logic               we;

  // Walker read owns the port
  assign addr = ptw_re_i ? ptw_addr_i : acc_addr_i;
  assign en   = ptw_re_i || acc_v_i;
  assign we   = !ptw_re_i && acc_v_i && acc_we_i;

  always_ff @(posedge clk_i) begin
    if (en) begin
      if (we) begin
        mem_q[addr] <= acc_wdata_i;
      end else begin
        rdata_o <= mem_q[addr];
      end
    end
  end

  // Decode stalls for the whole walk
  assert property (@(posedge clk_i) ptw_re_i |-> !acc_v_i);

endmodule

// File: logic/mmu_dtlb.sv
`timescale 1ns/1ps
// Fully associative data TLB
// Combinational lookup, refill to a free or round-robin entry, full flush
module mmu_dtlb #(
  parameter int TLB_ENTRIES = 4
) (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           flush_i,
  input  logic [mmu_addr_pkg::VPN_W-1:0] r_vpn_i,
  input  logic                           w_v_i,
  input  logic [mmu_addr_pkg::VPN_W-1:0] w_vpn_i,
  input  logic [mmu_addr_pkg::PPN_W-1:0] w_ppn_i,
  input  logic                           w_writable_i,
  output logic                           hit_o,
  output logic [mmu_addr_pkg::PPN_W-1:0] ppn_o,
  output logic                           writable_o
);
  import mmu_addr_pkg::*;

  localparam int IDX_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

  logic [TLB_ENTRIES-1:0] v_q;
  logic [TLB_ENTRIES-1:0] wr_q;
  logic [VPN_W-1:0]       vpn_q [TLB_ENTRIES];
  logic [PPN_W-1:0]       ppn_q [TLB_ENTRIES];
  logic [TLB_ENTRIES-1:0] match;
  logic [IDX_W-1:0]       victim_q;
  logic [IDX_W-1:0]       fill_idx;
  logic                   free_found;

  always_comb begin
    hit_o      = 1'b0;
    ppn_o      = '0;
    writable_o = 1'b0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      match[i] = v_q[i] && (vpn_q[i] == r_vpn_i);
      if (match[i]) begin
        hit_o      = 1'b1;
        ppn_o      = ppn_q[i];
        writable_o = wr_q[i];
      end
    end
  end

  // Lowest free entry first, else the victim
  always_comb begin
    fill_idx   = victim_q;
    free_found = 1'b0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      if (!v_q[i] && !free_found) begin
        fill_idx   = IDX_W'(i);
        free_found = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_q      <= '0;
      victim_q <= '0;
    end else if (flush_i) begin
      v_q <= '0;
    end else if (w_v_i) begin
      v_q[fill_idx] <= 1'b1;
      if (!free_found) begin
        victim_q <= (victim_q == IDX_W'(TLB_ENTRIES - 1)) ? '0 : victim_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (w_v_i) begin
      vpn_q[fill_idx] <= w_vpn_i;
      ppn_q[fill_idx] <= w_ppn_i;
      wr_q[fill_idx]  <= w_writable_i;
    end
  end

  // Refills only follow misses, so a VPN lives in at most one entry
  assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(match));

endmodule

// File: logic/mmu_ptw.sv
`timescale 1ns/1ps
// Single-level page table walker
// Reads one PTE from data memory, then refills the TLB or reports a fault
module mmu_ptw (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             miss_v_i,
  input  logic [mmu_addr_pkg::VPN_W-1:0]   miss_vpn_i,
  input  logic [mmu_addr_pkg::PPN_W-1:0]   base_ppn_i,
  input  logic [mmu_addr_pkg::WORD_W-1:0]  mem_rdata_i,
  output logic                             busy_o,
  output logic                             mem_re_o,
  output logic [mmu_addr_pkg::PADDR_W-1:0] mem_addr_o,
  output logic                             tlb_w_v_o,
  output logic [mmu_addr_pkg::VPN_W-1:0]   tlb_w_vpn_o,
  output logic [mmu_addr_pkg::PPN_W-1:0]   tlb_w_ppn_o,
  output logic                             tlb_w_writable_o,
  output logic                             done_o,
  output logic                             fault_o
);
  import mmu_addr_pkg::*;

  localparam logic [1:0] S_IDLE   = 2'd0;
  localparam logic [1:0] S_READ   = 2'd1;
  localparam logic [1:0] S_DECIDE = 2'd2;

  logic [1:0]       state_q;
  logic [VPN_W-1:0] vpn_q;
  mem_word_u        word;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= S_IDLE;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (miss_v_i) begin
            state_q <= S_READ;
          end
        end
        S_READ:  state_q <= S_DECIDE;
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == S_IDLE) && miss_v_i) begin
      vpn_q <= miss_vpn_i;
    end
  end

  // PTE address is base page then VPN
  assign mem_addr_o = {base_ppn_i, vpn_q};
  assign mem_re_o   = (state_q == S_READ);
  assign busy_o     = (state_q != S_IDLE);

  assign word    = mem_rdata_i;
  assign done_o  = (state_q == S_DECIDE) && word.pte.valid;
  assign fault_o = (state_q == S_DECIDE) && !word.pte.valid;

  assign tlb_w_v_o        = done_o;
  assign tlb_w_vpn_o      = vpn_q;
  assign tlb_w_ppn_o      = word.pte.ppn;
  assign tlb_w_writable_o = word.pte.writable;

  // No new miss while a walk is in flight
  assert property (@(posedge clk_i) disable iff (reset_i)
    busy_o |-> !miss_v_i);

endmodule

// File: logic/mmu_resp.sv
`timescale 1ns/1ps
// MMU response stage
// Aligns issue results with memory read data and pulses one response each
module mmu_resp (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            iss_v_i,
  input  mmu_cmd_pkg::mmu_op_e            iss_op_i,
  input  logic                            iss_fault_i,
  input  logic [mmu_addr_pkg::WORD_W-1:0] mem_rdata_i,
  output logic                            resp_v_o,
  output logic [mmu_addr_pkg::WORD_W-1:0] resp_data_o,
  output mmu_cmd_pkg::mmu_cause_e         resp_cause_o
);
  import mmu_cmd_pkg::*;

  logic    pend_v_q;
  mmu_op_e pend_op_q;
  logic    pend_fault_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pend_v_q <= 1'b0;
      resp_v_o <= 1'b0;
    end else begin
      pend_v_q <= iss_v_i;
      resp_v_o <= pend_v_q;
    end
  end

  // Memory data lines up with the pending entry
  always_ff @(posedge clk_i) begin
    pend_op_q    <= iss_op_i;
    pend_fault_q <= iss_fault_i;
    if (pend_v_q && (pend_op_q == OP_LOAD) && !pend_fault_q) begin
      resp_data_o <= mem_rdata_i;
    end else begin
      resp_data_o <= '0;
    end
    if (pend_v_q && pend_fault_q) begin
      resp_cause_o <= (pend_op_q == OP_STORE) ? CAUSE_STORE_PF : CAUSE_LOAD_PF;
    end else begin
      resp_cause_o <= CAUSE_NONE;
    end
  end

endmodule

// File: logic/mmu_top.sv
`timescale 1ns/1ps
// MMU top level
// Connects decode, data TLB, page table walker, data memory and response stage
module mmu_top #(
  parameter int TLB_ENTRIES = 4
) (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             cmd_v_i,
  input  mmu_cmd_pkg::mmu_op_e             cmd_op_i,
  input  logic [mmu_addr_pkg::VADDR_W-1:0] cmd_vaddr_i,
  input  logic [mmu_addr_pkg::WORD_W-1:0]  cmd_data_i,
  output logic                             cmd_ready_o,
  output logic                             resp_v_o,
  output logic [mmu_addr_pkg::WORD_W-1:0]  resp_data_o,
  output mmu_cmd_pkg::mmu_cause_e          resp_cause_o
);
  import mmu_addr_pkg::*;
  import mmu_cmd_pkg::*;

  logic [VPN_W-1:0]   tlb_vpn;
  logic               tlb_flush;
  logic               tlb_hit;
  logic [PPN_W-1:0]   tlb_ppn;
  logic               tlb_writable;
  logic               miss_v;
  logic [VPN_W-1:0]   miss_vpn;
  logic [PPN_W-1:0]   base_ppn;
  logic               ptw_re;
  logic [PADDR_W-1:0] ptw_addr;
  logic               ptw_w_v;
  logic [VPN_W-1:0]   ptw_w_vpn;
  logic [PPN_W-1:0]   ptw_w_ppn;
  logic               ptw_w_writable;
  logic               ptw_done;
  logic               ptw_fault;
  logic               mem_v;
  logic               mem_we;
  logic [PADDR_W-1:0] mem_addr;
  logic [WORD_W-1:0]  mem_wdata;
  logic [WORD_W-1:0]  mem_rdata;
  logic               iss_v;
  mmu_op_e            iss_op;
  logic               iss_fault;

  mmu_cmd_decode u_decode (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .cmd_v_i        (cmd_v_i),
    .cmd_op_i       (cmd_op_i),
    .cmd_vaddr_i    (cmd_vaddr_i),
    .cmd_data_i     (cmd_data_i),
    .tlb_hit_i      (tlb_hit),
    .tlb_ppn_i      (tlb_ppn),
    .tlb_writable_i (tlb_writable),
    .ptw_done_i     (ptw_done),
    .ptw_fault_i    (ptw_fault),
    .cmd_ready_o    (cmd_ready_o),
    .tlb_vpn_o      (tlb_vpn),
    .tlb_flush_o    (tlb_flush),
    .miss_v_o       (miss_v),
    .miss_vpn_o     (miss_vpn),
    .base_ppn_o     (base_ppn),
    .mem_v_o        (mem_v),
    .mem_we_o       (mem_we),
    .mem_addr_o     (mem_addr),
    .mem_wdata_o    (mem_wdata),
    .iss_v_o        (iss_v),
    .iss_op_o       (iss_op),
    .iss_fault_o    (iss_fault)
  );

  mmu_dtlb #(
    .TLB_ENTRIES (TLB_ENTRIES)
  ) u_dtlb (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .flush_i      (tlb_flush),
    .r_vpn_i      (tlb_vpn),
    .w_v_i        (ptw_w_v),
    .w_vpn_i      (ptw_w_vpn),
    .w_ppn_i      (ptw_w_ppn),
    .w_writable_i (ptw_w_writable),
    .hit_o        (tlb_hit),
    .ppn_o        (tlb_ppn),
    .writable_o   (tlb_writable)
  );

  mmu_ptw u_ptw (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .miss_v_i         (miss_v),
    .miss_vpn_i       (miss_vpn),
    .base_ppn_i       (base_ppn),
    .mem_rdata_i      (mem_rdata),
    .busy_o           (),
    .mem_re_o         (ptw_re),
    .mem_addr_o       (ptw_addr),
    .tlb_w_v_o        (ptw_w_v),
    .tlb_w_vpn_o      (ptw_w_vpn),
    .tlb_w_ppn_o      (ptw_w_ppn),
    .tlb_w_writable_o (ptw_w_writable),
    .done_o           (ptw_done),
    .fault_o          (ptw_fault)
  );

  mmu_data_mem u_mem (
    .clk_i       (clk_i),
    .acc_v_i     (mem_v),
    .acc_we_i    (mem_we),
    .acc_addr_i  (mem_addr),
    .acc_wdata_i (mem_wdata),
    .ptw_re_i    (ptw_re),
    .ptw_addr_i  (ptw_addr),
    .rdata_o     (mem_rdata)
  );

  mmu_resp u_resp (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .iss_v_i      (iss_v),
    .iss_op_i     (iss_op),
    .iss_fault_i  (iss_fault),
    .mem_rdata_i  (mem_rdata),
    .resp_v_o     (resp_v_o),
    .resp_data_o  (resp_data_o),
    .resp_cause_o (resp_cause_o)
  );

endmodule

// File: mmu_top.f
logic/mmu_addr_pkg.sv
logic/mmu_cmd_pkg.sv
logic/mmu_cmd_decode.sv
logic/mmu_dtlb.sv
logic/mmu_ptw.sv
logic/mmu_data_mem.sv
logic/mmu_resp.sv
logic/mmu_top.sv
tb/mmu_top_tb.sv

// File: tb/mmu_top_tb.sv
`timescale 1ns/1ps
// MMU testbench
// Table-driven loads, stores and translation control against a reference memory model
module mmu_top_tb;
  import mmu_addr_pkg::*;
  import mmu_cmd_pkg::*;

  localparam int TLB_ENTRIES    = 4;
  localparam int RESET_CYCLES   = 8;
  localparam int CYCLES_PER_CMD = 40;
  localparam int DRIVE_DLY      = 10;
  localparam int CLK_PERIOD     = 100;
  localparam int FIXED_LAT      = 2;

  typedef struct packed {
    mmu_op_e            op;
    logic [VADDR_W-1:0] vaddr;
    logic [WORD_W-1:0]  data;
    mmu_cause_e         cause;
  } cmd_entry_s;

  logic               clk_i = 1'b0;
  logic               reset_i;
  logic               cmd_v_i;
  mmu_op_e            cmd_op_i;
  logic [VADDR_W-1:0] cmd_vaddr_i;
  logic [WORD_W-1:0]  cmd_data_i;
  logic               cmd_ready_o;
  logic               resp_v_o;
  logic [WORD_W-1:0]  resp_data_o;
  mmu_cause_e         resp_cause_o;

  cmd_entry_s         cmd_table [$];
  logic [WORD_W-1:0]  ref_mem [2**PADDR_W];
  logic               ref_xlate = 1'b0;
  logic [PPN_W-1:0]   ref_base = '0;
  logic [WORD_W-1:0]  exp_data_q [$];
  mmu_cause_e         exp_cause_q [$];
  int                 exp_idx_q [$];
  time                acc_time_q [$];
  logic               fixed_lat_q [$];
  int                 n_checks = 0;
  int                 n_mismatch = 0;
  int                 n_other = 0;
  int                 cycle_cnt = 0;
  int                 timeout_limit = CYCLES_PER_CMD * 64;

  mmu_top #(
    .TLB_ENTRIES (TLB_ENTRIES)
  ) u_dut (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .cmd_v_i      (cmd_v_i),
    .cmd_op_i     (cmd_op_i),
    .cmd_vaddr_i  (cmd_vaddr_i),
    .cmd_data_i   (cmd_data_i),
    .cmd_ready_o  (cmd_ready_o),
    .resp_v_o     (resp_v_o),
    .resp_data_o  (resp_data_o),
    .resp_cause_o (resp_cause_o)
  );

  // 100 ns period
  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic check_val(input string name, input logic [WORD_W-1:0] got,
                           input logic [WORD_W-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_mismatch++;
      $display("Mismatch %s at %0t: got 0x%h, expected 0x%h", name, $time, got, exp);
    end
  endtask

  task automatic report_and_finish();
    $display("Checks: %0d, mismatches: %0d, other errors: %0d", n_checks, n_mismatch, n_other);
    if ((n_mismatch == 0) && (n_other == 0)) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  endtask

  function automatic logic [WORD_W-1:0] pte_word(input logic valid, input logic writable,
                                                 input logic [PPN_W-1:0] ppn);
    mem_word_u w;
    w.data       = '0;
    w.pte.valid    = valid;
    w.pte.writable = writable;
    w.pte.ppn      = ppn;
    return w.data;
  endfunction

  task automatic add_cmd(input mmu_op_e op, input logic [VADDR_W-1:0] vaddr,
                         input logic [WORD_W-1:0] data, input mmu_cause_e cause);
    cmd_entry_s e;
    e.op    = op;
    e.vaddr = vaddr;
    e.data  = data;
    e.cause = cause;
    cmd_table.push_back(e);
  endtask

  task automatic build_table();
    // Translation off, page is the low VPN bits
    add_cmd(OP_STORE, 16'h0010, 32'hA000_0010, CAUSE_NONE);
    add_cmd(OP_STORE, 16'h0120, 32'hA000_0120, CAUSE_NONE);
    add_cmd(OP_STORE, 16'h0230, 32'hA000_0230, CAUSE_NONE);
    add_cmd(OP_STORE, 16'h5141, 32'hA000_0141, CAUSE_NONE);
    add_cmd(OP_LOAD,  16'h0010, '0, CAUSE_NONE);
    add_cmd(OP_LOAD,  16'h0120, '0, CAUSE_NONE);
    add_cmd(OP_LOAD,  16'h0230, '0, CAUSE_NONE);
    add_cmd(OP_LOAD,  16'h0141, '0, CAUSE_NONE);
    add_cmd(OP_STORE, 16'h0044, 32'hA000_0044, CAUSE_NONE);
    add_cmd(OP_LOAD,  16'h0044, '0, CAUSE_NONE);
    add_cmd(OP_STORE, 16'h0044, 32'hB000_0044, CAUSE_NONE);
    add_cmd(OP_LOAD,  16'h0044, '0, CAUSE_NONE);
    // Page table lives in page 3
    add_cmd(OP_STORE, 16'h0310, pte_word(1'b1, 1'b1, 2'd0), CAUSE_NONE);
    add_cmd(OP_STORE, 16'h0311, pte_word(1'b1, 1'b0, 2'd1), CAUSE_NONE);
    add_cmd(OP_STORE, 16'h0312, pte_word(1'b1, 1'b1, 2'd2), CAUSE_NONE);
    add_cmd(OP_STORE, 16'h0313, pte_word(1'b0, 1'b1, 2'd3), CAUSE_NONE);
    add_cmd(OP_STORE, 16'h0314, pte_word(1'b1, 1'b1, 2'd0), CAUSE_NONE);
    add_cmd(OP_STORE, 16'h0315, pte_word(1'b1, 1'b1, 2'd1), CAUSE_NONE);
    add_cmd(OP_SATP,  16'h0000, 32'h8000_0003, CAUSE_NONE);
    // First touch of each VPN misses, repeats hit
    add_cmd(OP_LOAD,  16'h1010, '0, CAUSE_NONE);
    add_cmd(OP_LOAD,  16'h1044, '0, CAUSE_NONE);
    add_cmd(OP_LOAD,  16'h1120, '0, CAUSE_NONE);
    add_cmd(OP_LOAD,  16'h1230, '0, CAUSE_NONE);
    add_cmd(OP_LOAD,  16'h1010, '0, CAUSE_NONE);
    add_cmd(OP_STORE, 16'h1250, 32'hC000_0250, CAUSE_NONE);
    add_cmd(OP_LOAD,  16'h1250, '0, CAUSE_NONE);
    // Read-only page
    add_cmd(OP_STORE, 16'h1120, 32'hDEAD_0120, CAUSE_STORE_PF);
    add_cmd(OP_LOAD,  16'h1120, '0, CAUSE_NONE);
    // Invalid entry
    add_cmd(OP_LOAD,  16'h1300, '0, CAUSE_LOAD_PF);
    add_cmd(OP_STORE, 16'h1300, 32'hDEAD_0300, CAUSE_STORE_PF);
    // More mapped pages than TLB entries
    add_cmd(OP_LOAD,  16'h1444, '0, CAUSE_NONE);
    add_cmd(OP_LOAD,  16'h1541, '0, CAUSE_NONE);
    add_cmd(OP_STORE, 16'h1560, 32'hC000_0160, CAUSE_NONE);
    add_cmd(OP_LOAD,  16'h1010, '0, CAUSE_NONE);
    add_cmd(OP_LOAD,  16'h1160, '0, CAUSE_NONE);
    // Remap VPN 0x10 to page 2, then fence
    add_cmd(OP_SATP,  16'h0000, 32'h0000_0003, CAUSE_NONE);
    add_cmd(OP_STORE, 16'h0310, pte_word(1'b1, 1'b1, 2'd2), CAUSE_NONE);
    add_cmd(OP_SATP,  16'h0000, 32'h8000_0003, CAUSE_NONE);
    add_cmd(OP_FENCE, 16'h0000, '0, CAUSE_NONE);
    add_cmd(OP_LOAD,  16'h1030, '0, CAUSE_NONE);
    add_cmd(OP_LOAD,  16'h1050, '0, CAUSE_NONE);
    add_cmd(OP_STORE, 16'h1070, 32'hC000_0270, CAUSE_NONE);
    add_cmd(OP_LOAD,  16'h1270, '0, CAUSE_NONE);
    add_cmd(OP_LOAD,  16'h1120, '0, CAUSE_NONE);
  endtask

  // Reference behavior straight from the page table in memory
  task automatic model_cmd(input mmu_op_e op, input logic [VADDR_W-1:0] vaddr,
                           input logic [WORD_W-1:0] wdata,
                           output logic [WORD_W-1:0] exp_data, output mmu_cause_e exp_cause);
    mem_word_u          entry;
    logic [PPN_W-1:0]   ppn;
    logic [PADDR_W-1:0] paddr;
    logic               allowed;
    exp_data  = '0;
    exp_cause = CAUSE_NONE;
    allowed   = 1'b1;
    ppn       = vaddr[OFFSET_W +: PPN_W];
    if (ref_xlate && ((op == OP_LOAD) || (op == OP_STORE))) begin
      entry.data = ref_mem[{ref_base, vaddr[VADDR_W-1:OFFSET_W]}];
      ppn        = entry.pte.ppn;
      if (!entry.pte.valid || ((op == OP_STORE) && !entry.pte.writable)) begin
        allowed   = 1'b0;
        exp_cause = (op == OP_STORE) ? CAUSE_STORE_PF : CAUSE_LOAD_PF;
      end
    end
    paddr = {ppn, vaddr[OFFSET_W-1:0]};
    case (op)
      OP_LOAD: begin
        if (allowed) begin
          exp_data = ref_mem[paddr];
        end
      end
      OP_STORE: begin
        if (allowed) begin
          ref_mem[paddr] = wdata;
        end
      end
      OP_SATP: begin
        ref_xlate = wdata[SATP_EN_BIT];
        ref_base  = wdata[PPN_W-1:0];
      end
      default: begin
      end
    endcase
  endtask

  task automatic issue_cmd(input int idx);
    logic [WORD_W-1:0] exp_data;
    mmu_cause_e        exp_cause;
    logic              fixed_lat;
    cmd_v_i     = 1'b1;
    cmd_op_i    = cmd_table[idx].op;
    cmd_vaddr_i = cmd_table[idx].vaddr;
    cmd_data_i  = cmd_table[idx].data;
    // Accepted at the rising edge after ready is seen high
    @(negedge clk_i);
    while (!cmd_ready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    // Untranslated accesses and control ops never stall
    fixed_lat = !ref_xlate || (cmd_table[idx].op == OP_SATP) ||
                (cmd_table[idx].op == OP_FENCE);
    model_cmd(cmd_table[idx].op, cmd_table[idx].vaddr, cmd_table[idx].data,
              exp_data, exp_cause);
    if (exp_cause != cmd_table[idx].cause) begin
      n_other++;
      $display("Entry %0d: the model gives cause %0d but the table expects cause %0d",
               idx, exp_cause, cmd_table[idx].cause);
    end
    exp_data_q.push_back(exp_data);
    exp_cause_q.push_back(exp_cause);
    exp_idx_q.push_back(idx);
    acc_time_q.push_back($time);
    fixed_lat_q.push_back(fixed_lat);
    #DRIVE_DLY;
  endtask

  task automatic check_resp();
    int   idx;
    int   lat;
    time  t_acc;
    logic fixed_lat;
    if (exp_data_q.size() == 0) begin
      n_other++;
      $display("A response arrived at %0t with no command outstanding", $time);
    end else begin
      idx       = exp_idx_q.pop_front();
      t_acc     = acc_time_q.pop_front();
      fixed_lat = fixed_lat_q.pop_front();
      lat       = int'(($time - t_acc) / CLK_PERIOD);
      check_val($sformatf("resp_data_o[%0d]", idx), resp_data_o, exp_data_q.pop_front());
      check_val($sformatf("resp_cause_o[%0d]", idx), resp_cause_o, exp_cause_q.pop_front());
      if (fixed_lat) begin
        check_val($sformatf("resp_v_o latency[%0d]", idx), lat, FIXED_LAT);
      end
    end
  endtask

  always @(negedge clk_i) begin
    if (!reset_i && resp_v_o) begin
      check_resp();
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > timeout_limit) begin
      n_other++;
      $display("Timeout after %0d cycles with %0d responses still outstanding",
               cycle_cnt, exp_data_q.size());
      report_and_finish();
    end
  end

  initial begin
    reset_i     = 1'b1;
    cmd_v_i     = 1'b0;
    cmd_op_i    = OP_LOAD;
    cmd_vaddr_i = '0;
    cmd_data_i  = '0;
    build_table();
    timeout_limit = CYCLES_PER_CMD * cmd_table.size() + RESET_CYCLES;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #DRIVE_DLY;
    reset_i = 1'b0;
    @(negedge clk_i);
    check_val("cmd_ready_o", cmd_ready_o, 1'b1);
    check_val("resp_v_o", resp_v_o, 1'b0);
    @(posedge clk_i);
    #DRIVE_DLY;
    for (int i = 0; i < cmd_table.size(); i++) begin
      issue_cmd(i);
    end
    cmd_v_i = 1'b0;
    while (exp_data_q.size() != 0) begin
      @(posedge clk_i);
    end
    // Catch any stray responses
    repeat (4) @(posedge clk_i);
    report_and_finish();
  end

endmodule
